/* Makefile */
# Verilator simulation of the gap injector

TOP := tb_gap_inject

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir

/* flist.f */
rtl/gap_pkg.sv
rtl/stream_delay.sv
rtl/gap_detector.sv
rtl/tx_source.sv
rtl/tx_arbiter.sv
rtl/stream_merge.sv
rtl/gap_inject_top.sv
verif/tb_gap_inject.sv

/* rtl/gap_detector.sv */
// Gap detector
// Watches the undelayed input for an idle run as wide as the requested packet
// and raises cts over the delayed copy of exactly those idle cycles

`timescale 1ns/1ps

module gap_detector import gap_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  logic           in_valid,
	input  logic           rts,
	input  logic [paw-1:0] rts_len,
	output logic           cts
);

	typedef enum logic [1:0] {
		st_wait_rts,
		st_wait_gap,
		st_wait_rising,
		st_wait_falling
	} state_t;

	state_t         state;
	logic [paw-1:0] gap_width;
	logic [paw-1:0] w_l;
	logic [paw-1:0] delay_cnt;
	logic [paw-1:0] rise_at;
	logic           is_gap;

	// gap_width counts idle cycles up to but not including this one
	assign is_gap = gap_width >= w_l;

	// a gap found at cycle d started at d-w, and its delayed copy starts at
	// d-w+latency, so the rise has to wait latency-w-2 cycles after detection
	assign rise_at = paw'(latency - 2) - w_l;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_wait_rts;
			cts       <= 1'b0;
			gap_width <= '0;
			delay_cnt <= '0;
		end else begin
			cts <= 1'b0;

			// idle-run counter saturates rather than wrapping
			if (in_valid) begin
				gap_width <= '0;
			end else if (gap_width != '1) begin
				gap_width <= gap_width + 1'b1;
			end

			case (state)
				st_wait_rts: begin
					if (rts) begin
						state <= st_wait_gap;
					end
				end
				st_wait_gap: begin
					delay_cnt <= '0;
					if (is_gap) begin
						state <= st_wait_rising;
					end
				end
				st_wait_rising: begin
					if (delay_cnt >= rise_at) begin
						delay_cnt <= '0;
						cts       <= 1'b1;
						state     <= st_wait_falling;
					end else begin
						delay_cnt <= delay_cnt + 1'b1;
					end
				end
				st_wait_falling: begin
					// cts is already high for the first cycle of this state
					delay_cnt <= delay_cnt + 1'b1;
					if (delay_cnt >= w_l - 1'b1) begin
						state <= st_wait_rts;
					end else begin
						cts <= 1'b1;
					end
				end
				default: begin
					state <= st_wait_rts;
				end
			endcase
		end
	end

	// width is taken once per request and held for the whole schedule
	always_ff @(posedge clk) begin
		if (state == st_wait_rts && rts) begin
			w_l <= rts_len;
		end
	end

	// the arbiter must only forward lengths the schedule can place
	a_width_legal: assert property (@(posedge clk) disable iff (rst)
		(state != st_wait_rts) |-> (w_l >= paw'(1) && w_l <= paw'(max_pkt)));

	// a finished schedule never leaves cts hanging
	a_no_idle_cts: assert property (@(posedge clk) disable iff (rst)
		(state == st_wait_rts) |-> !cts);

endmodule

/* rtl/gap_inject_top.sv */
// Gap-scheduled packet injector
// Delays the byte stream by latency cycles and drops packets from two
// transmit sources into idle gaps of the delayed stream

`timescale 1ns/1ps

module gap_inject_top import gap_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  logic [data_w-1:0] in_data,
	input  logic [n_src-1:0]  load,
	input  logic [paw-1:0]    load_len0,
	input  logic [paw-1:0]    load_len1,
	input  logic [data_w-1:0] load_seed0,
	input  logic [data_w-1:0] load_seed1,
	output logic              out_valid,
	output logic [data_w-1:0] out_data,
	output src_t              out_src,
	output logic [n_src-1:0]  tx_busy
);

	logic              dly_valid;
	logic [data_w-1:0] dly_data;
	logic              cts;
	logic              rts;
	logic [paw-1:0]    rts_len;
	logic [n_src-1:0]  grant;
	logic [n_src-1:0]  req;
	logic [n_src-1:0]  word_valid;
	logic [paw-1:0]    len0;
	logic [paw-1:0]    len1;
	logic [data_w-1:0] word0;
	logic [data_w-1:0] word1;

	stream_delay u_delay (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.dly_valid (dly_valid),
		.dly_data  (dly_data)
	);

	// the detector looks at the undelayed stream to plan ahead
	gap_detector u_detect (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.rts      (rts),
		.rts_len  (rts_len),
		.cts      (cts)
	);

	tx_arbiter u_arb (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.len0    (len0),
		.len1    (len1),
		.cts     (cts),
		.grant   (grant),
		.rts     (rts),
		.rts_len (rts_len)
	);

	tx_source u_src0 (
		.clk        (clk),
		.rst        (rst),
		.load       (load[0]),
		.load_len   (load_len0),
		.load_seed  (load_seed0),
		.grant      (grant[0]),
		.cts        (cts),
		.req        (req[0]),
		.len        (len0),
		.word       (word0),
		.word_valid (word_valid[0]),
		.busy       (tx_busy[0])
	);

	tx_source u_src1 (
		.clk        (clk),
		.rst        (rst),
		.load       (load[1]),
		.load_len   (load_len1),
		.load_seed  (load_seed1),
		.grant      (grant[1]),
		.cts        (cts),
		.req        (req[1]),
		.len        (len1),
		.word       (word1),
		.word_valid (word_valid[1]),
		.busy       (tx_busy[1])
	);

	stream_merge u_merge (
		.clk       (clk),
		.rst       (rst),
		.dly_valid (dly_valid),
		.dly_data  (dly_data),
		.cts       (cts),
		.grant     (grant),
		.word0     (word0),
		.word1     (word1),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_src   (out_src)
	);

	// every cts cycle is backed by exactly one granted source with a word to send
	a_cts_backed: assert property (@(posedge clk) disable iff (rst)
		cts |-> $onehot(word_valid));

endmodule

/* rtl/gap_pkg.sv */
// Gap injector shared definitions
// Widths, delay-line latency and the origin tag carried on every output word

package gap_pkg;

	// one stream word is a byte
	localparam int data_w = 8;

	// packet-width field, wide enough for any legal packet length
	localparam int paw = 5;

	// delay of the stream delay line, and the horizon of the gap schedule
	localparam int latency = 16;

	// address width of the delay-line ring buffer
	localparam int dly_aw = $clog2(latency);

	// the detector needs two cycles of slack between detection and the
	// delayed gap, so a packet can be at most latency minus 2 words long
	localparam int max_pkt = latency - 2;

	// number of transmit sources sharing the injection slot
	localparam int n_src = 2;

	// origin of each output word
	// src_none marks an idle output cycle and src_pass a delayed input word
	typedef enum logic [1:0] {
		src_none = 2'd0,
		src_pass = 2'd1,
		src_tx0  = 2'd2,
		src_tx1  = 2'd3
	} src_t;

endpackage

/* rtl/stream_delay.sv */
// Stream delay line
// Replays the valid-qualified input stream exactly latency cycles later
// from a circular buffer with a single shared write/read pointer

`timescale 1ns/1ps

module stream_delay import gap_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  logic [data_w-1:0] in_data,
	output logic              dly_valid,
	output logic [data_w-1:0] dly_data
);

	// data storage, one entry per cycle of delay
	logic [data_w-1:0] data_mem [latency];

	// valid bits are kept apart so reset can clear them
	logic [latency-1:0] valid_mem;

	// the slot under the pointer holds the word written latency cycles ago
	logic [dly_aw-1:0] ptr;

	// the pointer walks the ring once every latency cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= '0;
		end else if (ptr == dly_aw'(latency - 1)) begin
			ptr <= '0;
		end else begin
			ptr <= ptr + 1'b1;
		end
	end

	// clearing the valid bits stops stale words leaking out after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_mem <= '0;
		end else begin
			valid_mem[ptr] <= in_valid;
		end
	end

	// the same slot is read before it is overwritten at the next edge
	always_ff @(posedge clk) begin
		data_mem[ptr] <= in_data;
	end

	// read side is combinational so the delay is exactly latency cycles
	assign dly_valid = valid_mem[ptr];
	assign dly_data  = data_mem[ptr];

endmodule

/* rtl/stream_merge.sv */
// Output merge
// Registers either the delayed input word or the granted source's word,
// and tags each output cycle with where its word came from

`timescale 1ns/1ps

module stream_merge import gap_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              dly_valid,
	input  logic [data_w-1:0] dly_data,
	input  logic              cts,
	input  logic [n_src-1:0]  grant,
	input  logic [data_w-1:0] word0,
	input  logic [data_w-1:0] word1,
	output logic              out_valid,
	output logic [data_w-1:0] out_data,
	output src_t              out_src
);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_src   <= src_none;
		end else if (cts) begin
			// injection slot, the word comes from whichever source holds the grant
			out_valid <= |grant;
			out_src   <= grant[1] ? src_tx1 : src_tx0;
		end else begin
			out_valid <= dly_valid;
			out_src   <= dly_valid ? src_pass : src_none;
		end
	end

	// idle cycles still carry the delayed data bits
	always_ff @(posedge clk) begin
		if (cts) begin
			out_data <= grant[1] ? word1 : word0;
		end else begin
			out_data <= dly_data;
		end
	end

	// cts must only cover delayed copies of idle input cycles
	a_no_collision: assert property (@(posedge clk) disable iff (rst)
		!(dly_valid && cts));

endmodule

/* rtl/tx_arbiter.sv */
// Round-robin slot arbiter
// Picks one pending source when the slot is free, hands its width to the
// gap detector and keeps the grant until the cts window has closed

`timescale 1ns/1ps

module tx_arbiter import gap_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic [n_src-1:0] req,
	input  logic [paw-1:0]   len0,
	input  logic [paw-1:0]   len1,
	input  logic             cts,
	output logic [n_src-1:0] grant,
	output logic             rts,
	output logic [paw-1:0]   rts_len
);

	// index of the source that won last time
	logic             last;
	logic             cts_q;
	logic             cts_fall;
	logic [n_src-1:0] pick;

	assign cts_fall = cts_q && !cts;

	// source 0 wins if it is alone or if source 1 had the last turn
	always_comb begin
		pick = '0;
		if (req[0] && (!req[1] || last)) begin
			pick[0] = 1'b1;
		end else if (req[1]) begin
			pick[1] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
			rts   <= 1'b0;
			last  <= 1'b1;
			cts_q <= 1'b0;
		end else begin
			cts_q <= cts;
			rts   <= 1'b0;
			if (grant == '0) begin
				// rts is a single-cycle pulse since grant is set alongside it
				if (|req) begin
					grant <= pick;
					rts   <= 1'b1;
				end
			end else if (cts_fall) begin
				grant <= '0;
				last  <= grant[1];
			end
		end
	end

	// width travels with the rts pulse
	always_ff @(posedge clk) begin
		if (grant == '0) begin
			rts_len <= pick[1] ? len1 : len0;
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant));

endmodule

/* rtl/tx_source.sv */
// Transmit source
// Holds one loaded packet, requests the injection slot and emits
// seed, seed+1 and so on while it is both granted and clear to send

`timescale 1ns/1ps

module tx_source import gap_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              load,
	input  logic [paw-1:0]    load_len,
	input  logic [data_w-1:0] load_seed,
	input  logic              grant,
	input  logic              cts,
	output logic              req,
	output logic [paw-1:0]    len,
	output logic [data_w-1:0] word,
	output logic              word_valid,
	output logic              busy
);

	logic [paw-1:0]    remain;
	logic [paw-1:0]    len_q;
	logic [data_w-1:0] word_q;

	// one word leaves on every cycle of the granted cts window
	assign word_valid = grant && cts;

	// the request lasts exactly as long as a packet is pending
	assign req  = busy;
	assign len  = len_q;
	assign word = word_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy   <= 1'b0;
			remain <= '0;
		end else if (!busy) begin
			// a load while a packet is pending is ignored
			if (load) begin
				busy   <= 1'b1;
				remain <= load_len;
			end
		end else if (word_valid) begin
			remain <= remain - 1'b1;
			if (remain == paw'(1)) begin
				busy <= 1'b0;
			end
		end
	end

	// packet contents, the next word is always the previous one plus one
	always_ff @(posedge clk) begin
		if (!busy && load) begin
			len_q  <= load_len;
			word_q <= load_seed;
		end else if (word_valid) begin
			word_q <= word_q + 1'b1;
		end
	end

	// the detector's cts window must never outlast the packet
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		word_valid |-> (busy && remain != '0));

endmodule

/* verif/tb_gap_inject.sv */
// Gap injector testbench
// Drives a random byte stream and random packet loads into both sources and
// checks every output cycle against a delay-line model and per-source packet records

`timescale 1ns/1ps

module tb_gap_inject import gap_pkg::*; ();

	// test lengths in cycles
	localparam int reset_cycles = 5;
	localparam int pass_cycles  = 300;
	localparam int rand_cycles  = 1200;
	localparam int both_cycles  = 1200;
	localparam int drain_max    = 200;

	// the run is cut off shortly after the longest legal schedule
	localparam int cycle_limit = reset_cycles + 1 + pass_cycles + rand_cycles
		+ both_cycles + drain_max + latency + 1 + 100;

	// stream shape, idle runs reach past max_pkt so every width can be placed
	localparam int max_idle  = 30;
	localparam int max_burst = 12;

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic [data_w-1:0] in_data;
	logic [n_src-1:0]  load;
	logic [paw-1:0]    load_len0;
	logic [paw-1:0]    load_len1;
	logic [data_w-1:0] load_seed0;
	logic [data_w-1:0] load_seed1;
	logic              out_valid;
	logic [data_w-1:0] out_data;
	src_t              out_src;
	logic [n_src-1:0]  tx_busy;

	integer seed;
	int     checks;
	int     errors;
	int     packets;
	int     cycles = 0;
	int     burst_left;
	int     idle_left;

	// driven input, one entry per cycle, packed as {known, valid, data}
	logic [data_w+1:0] dly_q [$];

	// one pending packet per source and the run that is on the output now
	logic              pend [n_src];
	logic [paw-1:0]    pkt_len [n_src];
	logic [data_w-1:0] pkt_seed [n_src];
	logic              run_on;
	logic              run_src;
	int                run_idx;

	// set when the other source was waiting as a packet finished
	logic alt_on;
	logic alt_src;

	gap_inject_top dut (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.load       (load),
		.load_len0  (load_len0),
		.load_len1  (load_len1),
		.load_seed0 (load_seed0),
		.load_seed1 (load_seed1),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_src    (out_src),
		.tx_busy    (tx_busy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// hard stop in case the DUT never drains its sources
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// tag that a source's words carry on the output
	function automatic src_t src_of(input logic s);
		return s ? src_tx1 : src_tx0;
	endfunction

	task automatic check_word(input string what, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_src(input string what, input src_t got, input src_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int n_checks, input int n_errors);
		$display("test %s done: %0d checks, %0d errors", name, n_checks, n_errors);
	endtask

	// closes a packet and checks the round-robin turn
	task automatic finish_packet(input logic s);
		if (alt_on && s != alt_src) begin
			errors++;
			$display("error %0t: source %0d finished out of turn, source %0d was waiting",
				$time, s, alt_src);
		end
		alt_on  = pend[!s];
		alt_src = !s;
		pend[s] = 1'b0;
		run_on  = 1'b0;
		packets++;
	endtask

	// one injected word, which must count up from the seed over an idle delayed cycle
	task automatic take_injected(input logic s, input logic dly_v);
		logic [data_w-1:0] exp_word;
		exp_word = data_w'(int'(pkt_seed[s]) + run_idx);
		if (dly_v) begin
			errors++;
			$display("error %0t: word from source %0d overwrote a valid input word", $time, s);
		end
		check_flag("out_valid", out_valid, 1'b1);
		check_word("injected word", out_data, exp_word);
		run_idx++;
		if (run_idx == int'(pkt_len[s])) begin
			finish_packet(s);
		end
	endtask

	task automatic check_outputs();
		logic [data_w+1:0] ent;
		logic              known;
		logic              dly_v;
		logic [data_w-1:0] dly_d;
		logic              s;
		ent   = dly_q.pop_front();
		known = ent[data_w+1];
		dly_v = ent[data_w];
		dly_d = ent[data_w-1:0];
		if (run_on) begin
			// a started packet runs without a break until its last word
			check_src("out_src", out_src, src_of(run_src));
			take_injected(run_src, dly_v);
		end else if (out_src == src_tx0 || out_src == src_tx1) begin
			s = (out_src == src_tx1);
			if (!pend[s]) begin
				errors++;
				$display("error %0t: source %0d injected with no packet loaded", $time, s);
			end else begin
				run_on  = 1'b1;
				run_src = s;
				run_idx = 0;
				take_injected(s, dly_v);
			end
		end else if (dly_v) begin
			check_src("out_src", out_src, src_pass);
			check_flag("out_valid", out_valid, 1'b1);
			check_word("pass-through word", out_data, dly_d);
		end else begin
			check_src("out_src", out_src, src_none);
			check_flag("out_valid", out_valid, 1'b0);
			// idle cycles still carry the delayed data bits
			if (known) begin
				check_word("idle data", out_data, dly_d);
			end
		end
		// busy must follow the model, rising after a load and falling with the last word
		check_flag("tx_busy[0]", tx_busy[0], pend[0]);
		check_flag("tx_busy[1]", tx_busy[1], pend[1]);
	endtask

	task automatic drive_inputs(input logic [n_src-1:0] load_en, input int load_pct,
		input int idle_pct);
		logic s;
		if (burst_left == 0 && idle_left == 0) begin
			if (rand_below(100) < idle_pct) begin
				idle_left = 1 + rand_below(max_idle);
			end else begin
				burst_left = 1 + rand_below(max_burst);
			end
		end
		// idle cycles get random data too, so a leak of idle data would show up
		in_data = data_w'($random(seed));
		if (burst_left > 0) begin
			in_valid = 1'b1;
			burst_left--;
		end else begin
			in_valid = 1'b0;
			idle_left--;
		end
		dly_q.push_back({1'b1, in_valid, in_data});
		load = '0;
		for (int i = 0; i < n_src; i++) begin
			s = 1'(i);
			if (load_en[s] && !pend[s] && rand_below(100) < load_pct) begin
				load[s]     = 1'b1;
				pend[s]     = 1'b1;
				pkt_len[s]  = paw'(1 + rand_below(max_pkt));
				pkt_seed[s] = data_w'($random(seed));
			end
		end
		load_len0  = pkt_len[0];
		load_len1  = pkt_len[1];
		load_seed0 = pkt_seed[0];
		load_seed1 = pkt_seed[1];
	endtask

	// one cycle, outputs checked and inputs driven on the falling edge
	task automatic step(input logic [n_src-1:0] load_en, input int load_pct,
		input int idle_pct);
		@(negedge clk);
		check_outputs();
		drive_inputs(load_en, load_pct, idle_pct);
	endtask

	task automatic run_test(input string name, input int n, input logic [n_src-1:0] load_en,
		input int load_pct, input int idle_pct);
		int chk0;
		int err0;
		chk0 = checks;
		err0 = errors;
		repeat (n) begin
			step(load_en, load_pct, idle_pct);
		end
		report_test(name, checks - chk0, errors - err0);
	endtask

	// idle input until both sources have sent, then flush the delay line
	task automatic drain();
		int chk0;
		int err0;
		int n;
		chk0 = checks;
		err0 = errors;
		n    = 0;
		while ((pend[0] || pend[1]) && n < drain_max) begin
			step('0, 0, 100);
			n++;
		end
		if (pend[0] || pend[1]) begin
			errors++;
			$display("drain: packets still waiting for a gap after %0d idle cycles", n);
		end
		repeat (latency + 1) begin
			step('0, 0, 100);
		end
		report_test("drain", checks - chk0, errors - err0);
	endtask

	initial begin
		seed       = 32'hfe29663f;
		checks     = 0;
		errors     = 0;
		packets    = 0;
		burst_left = 0;
		idle_left  = 0;
		run_on     = 1'b0;
		run_src    = 1'b0;
		run_idx    = 0;
		alt_on     = 1'b0;
		alt_src    = 1'b0;
		for (int i = 0; i < n_src; i++) begin
			pend[i]     = 1'b0;
			pkt_len[i]  = '0;
			pkt_seed[i] = '0;
		end
		rst        = 1'b1;
		in_valid   = 1'b0;
		in_data    = '0;
		load       = '0;
		load_len0  = '0;
		load_len1  = '0;
		load_seed0 = '0;
		load_seed1 = '0;

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		// the delay line comes out of reset empty, its data bits unknown
		repeat (latency) dly_q.push_back({1'b0, 1'b0, data_w'(0)});
		dly_q.push_back({1'b1, 1'b0, in_data});
		check_flag("out_valid", out_valid, 1'b0);
		check_src("out_src", out_src, src_none);
		check_flag("tx_busy[0]", tx_busy[0], 1'b0);
		check_flag("tx_busy[1]", tx_busy[1], 1'b0);
		rst = 1'b0;
		report_test("reset_state", checks, errors);

		run_test("pass_through", pass_cycles, '0, 0, 40);
		run_test("random_loads", rand_cycles, '1, 4, 55);
		// sources reload at once, so both are pending nearly all the time
		run_test("both_pending", both_cycles, '1, 100, 65);
		drain();

		$display("summary: %0d checks, %0d errors, %0d packets injected",
			checks, errors, packets);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
